//--- csr_types_pkg.sv
// Shared CSR register map, vector typedefs and test engine state encoding
package csr_types_pkg;

    // Word index of a CSR as carried by a host write
    typedef logic [15:0] csr_addr_t;

    // CSR write payload and status-register read value
    typedef logic [31:0] csr_data_t;

    // Byte address in host memory
    typedef logic [63:0] mem_addr_t;

    // Line count of a test and the running line index
    typedef logic [15:0] line_count_t;

    // Status-register index carried by a status read request
    typedef logic [3:0] sreg_idx_t;

    // Test engine states
    typedef enum logic {
        ENGINE_IDLE = 1'b0,
        ENGINE_RUN  = 1'b1
    } engine_state_t;

    // Status area base with the low half at the lower index
    localparam csr_addr_t CSR_DSM_BASEL         = 16'h0010;
    localparam csr_addr_t CSR_DSM_BASEH         = 16'h0011;

    // Accelerator enable taken from bit 0 of the payload
    localparam csr_addr_t CSR_AFU_EN            = 16'h0012;

    // Source and destination frame bases
    localparam csr_addr_t CSR_READ_FRAME_BASEL  = 16'h0013;
    localparam csr_addr_t CSR_READ_FRAME_BASEH  = 16'h0014;
    localparam csr_addr_t CSR_WRITE_FRAME_BASEL = 16'h0015;
    localparam csr_addr_t CSR_WRITE_FRAME_BASEH = 16'h0016;

    // Commands for a test start with its line count and for a status read
    localparam csr_addr_t CSR_ENABLE_TEST       = 16'h0017;
    localparam csr_addr_t CSR_SREG_READ         = 16'h0018;

    // Status-register indices where any other index reads back as zero
    localparam sreg_idx_t SREG_TESTS_DONE       = 4'd0;
    localparam sreg_idx_t SREG_LINES_TOTAL      = 4'd1;
    localparam sreg_idx_t SREG_ENGINE_BUSY      = 4'd2;
    localparam sreg_idx_t SREG_DSM_BASEL        = 4'd3;

endpackage

//--- csr_decoder.sv
// Host CSR write decoder producing held configuration state and command pulses
`timescale 1ns/10ps

module csr_decoder (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       cfg_valid,
    input  csr_types_pkg::csr_addr_t   cfg_addr,
    input  csr_types_pkg::csr_data_t   cfg_data,
    output logic                       afu_en,
    output csr_types_pkg::mem_addr_t   dsm_base,
    output logic                       dsm_base_valid,
    output csr_types_pkg::mem_addr_t   read_frame_base,
    output csr_types_pkg::mem_addr_t   write_frame_base,
    output logic                       test_start,
    output csr_types_pkg::line_count_t test_lines,
    output logic                       sreg_req,
    output csr_types_pkg::sreg_idx_t   sreg_idx
);

    // One hit per register-map entry, qualified by the write strobe
    logic hit_dsm_basel;
    logic hit_dsm_baseh;
    logic hit_afu_en;
    logic hit_rd_basel;
    logic hit_rd_baseh;
    logic hit_wr_basel;
    logic hit_wr_baseh;
    logic hit_enable_test;
    logic hit_sreg_read;

    assign hit_dsm_basel   = cfg_valid && (cfg_addr == csr_types_pkg::CSR_DSM_BASEL);
    assign hit_dsm_baseh   = cfg_valid && (cfg_addr == csr_types_pkg::CSR_DSM_BASEH);
    assign hit_afu_en      = cfg_valid && (cfg_addr == csr_types_pkg::CSR_AFU_EN);
    assign hit_rd_basel    = cfg_valid && (cfg_addr == csr_types_pkg::CSR_READ_FRAME_BASEL);
    assign hit_rd_baseh    = cfg_valid && (cfg_addr == csr_types_pkg::CSR_READ_FRAME_BASEH);
    assign hit_wr_basel    = cfg_valid && (cfg_addr == csr_types_pkg::CSR_WRITE_FRAME_BASEL);
    assign hit_wr_baseh    = cfg_valid && (cfg_addr == csr_types_pkg::CSR_WRITE_FRAME_BASEH);
    assign hit_enable_test = cfg_valid && (cfg_addr == csr_types_pkg::CSR_ENABLE_TEST);
    assign hit_sreg_read   = cfg_valid && (cfg_addr == csr_types_pkg::CSR_SREG_READ);

    // Status area base halves are stored independently as they arrive
    always_ff @(posedge clk) begin
        if (hit_dsm_basel) begin
            dsm_base[31:0] <= cfg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_dsm_baseh) begin
            dsm_base[63:32] <= cfg_data;
        end
    end

    // The base counts as usable once its low half has been written
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dsm_base_valid <= 1'b0;
        end else if (hit_dsm_basel) begin
            dsm_base_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            afu_en <= 1'b0;
        end else if (hit_afu_en) begin
            afu_en <= cfg_data[0];
        end
    end

    // Frame bases for the read and write streams
    always_ff @(posedge clk) begin
        if (hit_rd_basel) begin
            read_frame_base[31:0] <= cfg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_rd_baseh) begin
            read_frame_base[63:32] <= cfg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_wr_basel) begin
            write_frame_base[31:0] <= cfg_data;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_wr_baseh) begin
            write_frame_base[63:32] <= cfg_data;
        end
    end

    // Command strobes last one cycle while their payload holds until the next command
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            test_start <= 1'b0;
            sreg_req   <= 1'b0;
        end else begin
            test_start <= hit_enable_test;
            sreg_req   <= hit_sreg_read;
        end
    end

    always_ff @(posedge clk) begin
        if (hit_enable_test) begin
            test_lines <= cfg_data[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (hit_sreg_read) begin
            sreg_idx <= cfg_data[3:0];
        end
    end

endmodule

//--- test_engine.sv
// Test engine stepping through frame lines and issuing paired read and write requests
`timescale 1ns/10ps

module test_engine #(
    parameter int LINE_BYTES_LOG2 = 6
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       afu_en,
    input  logic                       test_start,
    input  csr_types_pkg::line_count_t test_lines,
    input  csr_types_pkg::mem_addr_t   read_frame_base,
    input  csr_types_pkg::mem_addr_t   write_frame_base,
    output logic                       req_valid,
    output csr_types_pkg::mem_addr_t   rd_addr,
    output csr_types_pkg::mem_addr_t   wr_addr,
    output logic                       test_done,
    output csr_types_pkg::line_count_t done_lines,
    output logic                       busy
);

    csr_types_pkg::engine_state_t state;

    // Index of the line whose request is on the outputs in this cycle
    csr_types_pkg::line_count_t   line_idx;
    csr_types_pkg::line_count_t   issued;
    csr_types_pkg::line_count_t   lines_q;
    csr_types_pkg::mem_addr_t     rd_base_q;
    csr_types_pkg::mem_addr_t     wr_base_q;
    csr_types_pkg::mem_addr_t     line_offset;
    logic                         start_ok;
    logic                         zero_start;
    logic                         run_stop;

    // A start is only honoured while enabled and not already running
    assign start_ok   = test_start && afu_en && (state == csr_types_pkg::ENGINE_IDLE);
    assign zero_start = start_ok && (test_lines == '0);

    // Requests issued so far, counting the one presented in this cycle
    assign issued = line_idx + csr_types_pkg::line_count_t'(1);

    // The run ends after the last line or as soon as the host drops the enable
    assign run_stop = (state == csr_types_pkg::ENGINE_RUN) && (!afu_en || (issued == lines_q));

    // Every cycle in the run state carries one request pair
    assign busy      = (state == csr_types_pkg::ENGINE_RUN);
    assign req_valid = busy;

    assign line_offset = csr_types_pkg::mem_addr_t'(line_idx) << LINE_BYTES_LOG2;
    assign rd_addr     = rd_base_q + line_offset;
    assign wr_addr     = wr_base_q + line_offset;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= csr_types_pkg::ENGINE_IDLE;
            line_idx  <= '0;
            test_done <= 1'b0;
        end else begin
            // A zero-line test completes without ever entering the run state
            test_done <= zero_start || run_stop;
            unique case (state)
                csr_types_pkg::ENGINE_IDLE: begin
                    if (start_ok && !zero_start) begin
                        state    <= csr_types_pkg::ENGINE_RUN;
                        line_idx <= '0;
                    end
                end
                csr_types_pkg::ENGINE_RUN: begin
                    if (run_stop) begin
                        state <= csr_types_pkg::ENGINE_IDLE;
                    end else begin
                        line_idx <= issued;
                    end
                end
            endcase
        end
    end

    // Test parameters are captured at start so later CSR writes do not disturb a run
    always_ff @(posedge clk) begin
        if (start_ok) begin
            lines_q   <= test_lines;
            rd_base_q <= read_frame_base;
            wr_base_q <= write_frame_base;
        end
    end

    // Completion payload follows the done strobe
    always_ff @(posedge clk) begin
        if (zero_start) begin
            done_lines <= '0;
        end else if (run_stop) begin
            done_lines <= issued;
        end
    end

endmodule

//--- status_unit.sv
// Test statistics, status-register read responses and DSM completion records
`timescale 1ns/10ps

module status_unit (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       test_done,
    input  csr_types_pkg::line_count_t done_lines,
    input  logic                       busy,
    input  csr_types_pkg::mem_addr_t   dsm_base,
    input  logic                       dsm_base_valid,
    input  logic                       sreg_req,
    input  csr_types_pkg::sreg_idx_t   sreg_idx,
    output logic                       dsm_wr_valid,
    output csr_types_pkg::mem_addr_t   dsm_wr_addr,
    output csr_types_pkg::csr_data_t   dsm_wr_data,
    output logic                       sreg_rsp_valid,
    output csr_types_pkg::csr_data_t   sreg_rsp_data
);

    // Running statistics that both wrap at 32 bits
    csr_types_pkg::csr_data_t tests_done;
    csr_types_pkg::csr_data_t lines_total;
    csr_types_pkg::csr_data_t done_lines_ext;
    csr_types_pkg::csr_data_t sreg_value;

    assign done_lines_ext = csr_types_pkg::csr_data_t'(done_lines);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tests_done  <= '0;
            lines_total <= '0;
        end else if (test_done) begin
            tests_done  <= tests_done + 32'd1;
            lines_total <= lines_total + done_lines_ext;
        end
    end

    // Select the requested status value and return zero for unmapped indices
    always_comb begin
        case (sreg_idx)
            csr_types_pkg::SREG_TESTS_DONE:  sreg_value = tests_done;
            csr_types_pkg::SREG_LINES_TOTAL: sreg_value = lines_total;
            csr_types_pkg::SREG_ENGINE_BUSY: sreg_value = csr_types_pkg::csr_data_t'(busy);
            csr_types_pkg::SREG_DSM_BASEL:   sreg_value = dsm_base[31:0];
            default:                         sreg_value = '0;
        endcase
    end

    // Strobes for the DSM write and the read response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            dsm_wr_valid   <= 1'b0;
            sreg_rsp_valid <= 1'b0;
        end else begin
            // No completion record is posted before the host has set up the status area
            dsm_wr_valid   <= test_done && dsm_base_valid;
            sreg_rsp_valid <= sreg_req;
        end
    end

    // The completion record carries the number of lines the test issued
    always_ff @(posedge clk) begin
        if (test_done) begin
            dsm_wr_addr <= dsm_base;
            dsm_wr_data <= done_lines_ext;
        end
    end

    always_ff @(posedge clk) begin
        if (sreg_req) begin
            sreg_rsp_data <= sreg_value;
        end
    end

endmodule

//--- afu_top.sv
// Accelerator top level joining the CSR decoder, test engine and status unit
`timescale 1ns/10ps

module afu_top #(
    parameter int LINE_BYTES_LOG2 = 6
) (
    input  logic                     clk,
    input  logic                     arst_n,
    input  logic                     cfg_valid,
    input  csr_types_pkg::csr_addr_t cfg_addr,
    input  csr_types_pkg::csr_data_t cfg_data,
    output logic                     req_valid,
    output csr_types_pkg::mem_addr_t rd_addr,
    output csr_types_pkg::mem_addr_t wr_addr,
    output logic                     dsm_wr_valid,
    output csr_types_pkg::mem_addr_t dsm_wr_addr,
    output csr_types_pkg::csr_data_t dsm_wr_data,
    output logic                     sreg_rsp_valid,
    output csr_types_pkg::csr_data_t sreg_rsp_data
);

    // Decoded configuration and commands
    logic                       afu_en;
    csr_types_pkg::mem_addr_t   dsm_base;
    logic                       dsm_base_valid;
    csr_types_pkg::mem_addr_t   read_frame_base;
    csr_types_pkg::mem_addr_t   write_frame_base;
    logic                       test_start;
    csr_types_pkg::line_count_t test_lines;
    logic                       sreg_req;
    csr_types_pkg::sreg_idx_t   sreg_idx;

    // Engine completion and activity
    logic                       test_done;
    csr_types_pkg::line_count_t done_lines;
    logic                       busy;

    csr_decoder i_csr_decoder (
        .clk              (clk),
        .arst_n           (arst_n),
        .cfg_valid        (cfg_valid),
        .cfg_addr         (cfg_addr),
        .cfg_data         (cfg_data),
        .afu_en           (afu_en),
        .dsm_base         (dsm_base),
        .dsm_base_valid   (dsm_base_valid),
        .read_frame_base  (read_frame_base),
        .write_frame_base (write_frame_base),
        .test_start       (test_start),
        .test_lines       (test_lines),
        .sreg_req         (sreg_req),
        .sreg_idx         (sreg_idx)
    );

    test_engine #(
        .LINE_BYTES_LOG2 (LINE_BYTES_LOG2)
    ) i_test_engine (
        .clk              (clk),
        .arst_n           (arst_n),
        .afu_en           (afu_en),
        .test_start       (test_start),
        .test_lines       (test_lines),
        .read_frame_base  (read_frame_base),
        .write_frame_base (write_frame_base),
        .req_valid        (req_valid),
        .rd_addr          (rd_addr),
        .wr_addr          (wr_addr),
        .test_done        (test_done),
        .done_lines       (done_lines),
        .busy             (busy)
    );

    status_unit i_status_unit (
        .clk              (clk),
        .arst_n           (arst_n),
        .test_done        (test_done),
        .done_lines       (done_lines),
        .busy             (busy),
        .dsm_base         (dsm_base),
        .dsm_base_valid   (dsm_base_valid),
        .sreg_req         (sreg_req),
        .sreg_idx         (sreg_idx),
        .dsm_wr_valid     (dsm_wr_valid),
        .dsm_wr_addr      (dsm_wr_addr),
        .dsm_wr_data      (dsm_wr_data),
        .sreg_rsp_valid   (sreg_rsp_valid),
        .sreg_rsp_data    (sreg_rsp_data)
    );

endmodule

//--- afu_assertions.sv
// Bound checker with a host-write shadow model and concurrent assertions on the accelerator outputs
`timescale 1ns/10ps

module afu_assertions #(
    parameter int LINE_BYTES = 64
) (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     cfg_valid,
    input csr_types_pkg::csr_addr_t cfg_addr,
    input csr_types_pkg::csr_data_t cfg_data,
    input logic                     req_valid,
    input csr_types_pkg::mem_addr_t rd_addr,
    input csr_types_pkg::mem_addr_t wr_addr,
    input logic                     dsm_wr_valid,
    input csr_types_pkg::mem_addr_t dsm_wr_addr,
    input csr_types_pkg::csr_data_t dsm_wr_data,
    input logic                     sreg_rsp_valid,
    input csr_types_pkg::csr_data_t sreg_rsp_data
);

    // Shadow of the host configuration, taken on the same edge as the decoder
    logic                       en_m;
    logic                       dsm_ok_m;
    csr_types_pkg::mem_addr_t   dsm_m;
    csr_types_pkg::mem_addr_t   rb_m;
    csr_types_pkg::mem_addr_t   wb_m;

    // Commands as seen one cycle after their write
    logic                       start_d;
    csr_types_pkg::line_count_t lines_d;
    logic                       sreq_d;
    csr_types_pkg::sreg_idx_t   idx_d;

    // Expected request stream of the running test
    logic                       exp_active;
    csr_types_pkg::line_count_t exp_idx;
    csr_types_pkg::line_count_t exp_lines;
    csr_types_pkg::mem_addr_t   rb_c;
    csr_types_pkg::mem_addr_t   wb_c;
    csr_types_pkg::mem_addr_t   rd_exp;
    csr_types_pkg::mem_addr_t   wr_exp;

    // Completion, statistics and expected responses
    logic                       done_m;
    csr_types_pkg::line_count_t done_n;
    logic                       dsm_exp;
    csr_types_pkg::mem_addr_t   dsm_addr_exp;
    csr_types_pkg::csr_data_t   dsm_data_exp;
    csr_types_pkg::csr_data_t   tests_m;
    csr_types_pkg::csr_data_t   lines_m;
    csr_types_pkg::csr_data_t   sel_m;
    logic                       rsp_exp;
    csr_types_pkg::csr_data_t   rsp_val;

    // Details of the first mismatch for the testbench to report
    logic                       fail_flag = 1'b0;
    string                      fail_what;
    logic [63:0]                fail_exp;
    logic [63:0]                fail_act;

    task automatic record_mismatch(input string what, input logic [63:0] exp_v,
                                   input logic [63:0] act_v);
        if (!fail_flag) begin
            fail_what = what;
            fail_exp  = exp_v;
            fail_act  = act_v;
        end
        fail_flag = 1'b1;
    endtask

    // Each request line sits one line size further into both frames
    assign rd_exp = rb_c + 64'(exp_idx) * 64'(LINE_BYTES);
    assign wr_exp = wb_c + 64'(exp_idx) * 64'(LINE_BYTES);

    // Status value the unit should select for the pending read
    always_comb begin
        case (idx_d)
            csr_types_pkg::SREG_TESTS_DONE:  sel_m = tests_m;
            csr_types_pkg::SREG_LINES_TOTAL: sel_m = lines_m;
            csr_types_pkg::SREG_ENGINE_BUSY: sel_m = {31'd0, exp_active};
            csr_types_pkg::SREG_DSM_BASEL:   sel_m = dsm_m[31:0];
            default:                         sel_m = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            en_m         <= 1'b0;
            dsm_ok_m     <= 1'b0;
            dsm_m        <= '0;
            rb_m         <= '0;
            wb_m         <= '0;
            start_d      <= 1'b0;
            lines_d      <= '0;
            sreq_d       <= 1'b0;
            idx_d        <= '0;
            exp_active   <= 1'b0;
            exp_idx      <= '0;
            exp_lines    <= '0;
            rb_c         <= '0;
            wb_c         <= '0;
            done_m       <= 1'b0;
            done_n       <= '0;
            dsm_exp      <= 1'b0;
            dsm_addr_exp <= '0;
            dsm_data_exp <= '0;
            tests_m      <= '0;
            lines_m      <= '0;
            rsp_exp      <= 1'b0;
            rsp_val      <= '0;
        end else begin
            start_d <= cfg_valid && (cfg_addr == csr_types_pkg::CSR_ENABLE_TEST);
            sreq_d  <= cfg_valid && (cfg_addr == csr_types_pkg::CSR_SREG_READ);
            if (cfg_valid) begin
                case (cfg_addr)
                    csr_types_pkg::CSR_DSM_BASEL: begin
                        dsm_m[31:0] <= cfg_data;
                        dsm_ok_m    <= 1'b1;
                    end
                    csr_types_pkg::CSR_DSM_BASEH:         dsm_m[63:32] <= cfg_data;
                    csr_types_pkg::CSR_AFU_EN:            en_m <= cfg_data[0];
                    csr_types_pkg::CSR_READ_FRAME_BASEL:  rb_m[31:0] <= cfg_data;
                    csr_types_pkg::CSR_READ_FRAME_BASEH:  rb_m[63:32] <= cfg_data;
                    csr_types_pkg::CSR_WRITE_FRAME_BASEL: wb_m[31:0] <= cfg_data;
                    csr_types_pkg::CSR_WRITE_FRAME_BASEH: wb_m[63:32] <= cfg_data;
                    csr_types_pkg::CSR_ENABLE_TEST:       lines_d <= cfg_data[15:0];
                    csr_types_pkg::CSR_SREG_READ:         idx_d <= cfg_data[3:0];
                    default: begin
                    end
                endcase
            end

            // A request is due in every cycle of a run until the count is reached or the enable drops
            done_m <= 1'b0;
            if (exp_active) begin
                exp_idx <= exp_idx + 16'd1;
                if (!en_m || (exp_idx + 16'd1 == exp_lines)) begin
                    exp_active <= 1'b0;
                    done_m     <= 1'b1;
                    done_n     <= exp_idx + 16'd1;
                end
            end else if (start_d && en_m) begin
                if (lines_d == '0) begin
                    done_m <= 1'b1;
                    done_n <= '0;
                end else begin
                    exp_active <= 1'b1;
                    exp_idx    <= '0;
                    exp_lines  <= lines_d;
                    rb_c       <= rb_m;
                    wb_c       <= wb_m;
                end
            end

            // Completion record follows the done pulse by one cycle
            dsm_exp <= done_m && dsm_ok_m;
            if (done_m) begin
                tests_m      <= tests_m + 32'd1;
                lines_m      <= lines_m + 32'(done_n);
                dsm_addr_exp <= dsm_m;
                dsm_data_exp <= 32'(done_n);
            end

            rsp_exp <= sreq_d;
            if (sreq_d) begin
                rsp_val <= sel_m;
            end
        end
    end

    a_req_valid: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid == exp_active)
    else begin
        record_mismatch("req_valid", 64'($sampled(exp_active)), 64'($sampled(req_valid)));
        $error("req_valid outside the expected request window");
    end

    a_rd_addr: assert property (@(posedge clk) disable iff (!arst_n)
        exp_active |-> rd_addr == rd_exp)
    else begin
        record_mismatch("rd_addr", $sampled(rd_exp), $sampled(rd_addr));
        $error("Wrong read request address");
    end

    a_wr_addr: assert property (@(posedge clk) disable iff (!arst_n)
        exp_active |-> wr_addr == wr_exp)
    else begin
        record_mismatch("wr_addr", $sampled(wr_exp), $sampled(wr_addr));
        $error("Wrong write request address");
    end

    a_dsm_valid: assert property (@(posedge clk) disable iff (!arst_n)
        dsm_wr_valid == dsm_exp)
    else begin
        record_mismatch("dsm_wr_valid", 64'($sampled(dsm_exp)), 64'($sampled(dsm_wr_valid)));
        $error("Unexpected or missing DSM completion write");
    end

    a_dsm_addr: assert property (@(posedge clk) disable iff (!arst_n)
        dsm_exp |-> dsm_wr_addr == dsm_addr_exp)
    else begin
        record_mismatch("dsm_wr_addr", $sampled(dsm_addr_exp), $sampled(dsm_wr_addr));
        $error("Wrong DSM completion address");
    end

    a_dsm_data: assert property (@(posedge clk) disable iff (!arst_n)
        dsm_exp |-> dsm_wr_data == dsm_data_exp)
    else begin
        record_mismatch("dsm_wr_data", 64'($sampled(dsm_data_exp)),
                        64'($sampled(dsm_wr_data)));
        $error("Wrong DSM completion line count");
    end

    a_rsp_valid: assert property (@(posedge clk) disable iff (!arst_n)
        sreg_rsp_valid == rsp_exp)
    else begin
        record_mismatch("sreg_rsp_valid", 64'($sampled(rsp_exp)),
                        64'($sampled(sreg_rsp_valid)));
        $error("Status read response at the wrong cycle");
    end

    a_rsp_data: assert property (@(posedge clk) disable iff (!arst_n)
        rsp_exp |-> sreg_rsp_data == rsp_val)
    else begin
        record_mismatch("sreg_rsp_data", 64'($sampled(rsp_val)),
                        64'($sampled(sreg_rsp_data)));
        $error("Wrong status register value");
    end

endmodule

//--- tb_afu_top.sv
// Testbench for the accelerator control slice with clock, reset, CSR traffic and watchdog
`timescale 1ns/10ps

module tb_afu_top;

    localparam int CLK_PERIOD  = 4;
    localparam int NUM_TESTS   = 8;
    localparam int TOTAL_LINES = 5 + 7 + 0 + 20 + 8;

    // Budget of 40 cycles per test plus one cycle per line
    localparam int WATCHDOG_NS = NUM_TESTS * 40 * CLK_PERIOD + TOTAL_LINES * CLK_PERIOD;

    logic                     clk;
    logic                     arst_n;
    logic                     cfg_valid;
    csr_types_pkg::csr_addr_t cfg_addr;
    csr_types_pkg::csr_data_t cfg_data;
    logic                     req_valid;
    csr_types_pkg::mem_addr_t rd_addr;
    csr_types_pkg::mem_addr_t wr_addr;
    logic                     dsm_wr_valid;
    csr_types_pkg::mem_addr_t dsm_wr_addr;
    csr_types_pkg::csr_data_t dsm_wr_data;
    logic                     sreg_rsp_valid;
    csr_types_pkg::csr_data_t sreg_rsp_data;
    integer                   seed;
    string                    test_name;

    afu_top #(
        .LINE_BYTES_LOG2 (6)
    ) i_dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .req_valid      (req_valid),
        .rd_addr        (rd_addr),
        .wr_addr        (wr_addr),
        .dsm_wr_valid   (dsm_wr_valid),
        .dsm_wr_addr    (dsm_wr_addr),
        .dsm_wr_data    (dsm_wr_data),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    // The checker sits inside the DUT and sees its host port and outputs
    bind afu_top afu_assertions i_afu_assertions (
        .clk            (clk),
        .arst_n         (arst_n),
        .cfg_valid      (cfg_valid),
        .cfg_addr       (cfg_addr),
        .cfg_data       (cfg_data),
        .req_valid      (req_valid),
        .rd_addr        (rd_addr),
        .wr_addr        (wr_addr),
        .dsm_wr_valid   (dsm_wr_valid),
        .dsm_wr_addr    (dsm_wr_addr),
        .dsm_wr_data    (dsm_wr_data),
        .sreg_rsp_valid (sreg_rsp_valid),
        .sreg_rsp_data  (sreg_rsp_data)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic report_failure();
        abort_run($sformatf("[FAIL] %s: %s expected %0h actual %0h", test_name,
                            i_dut.i_afu_assertions.fail_what,
                            i_dut.i_afu_assertions.fail_exp,
                            i_dut.i_afu_assertions.fail_act));
    endtask

    // All stimulus tasks start and end 1 ns after a rising edge
    task automatic idle(input int cycles);
        repeat (cycles) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic host_write(input csr_types_pkg::csr_addr_t addr,
                              input csr_types_pkg::csr_data_t data);
        cfg_valid = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        idle(1);
        cfg_valid = 1'b0;
    endtask

    task automatic set_frame_bases();
        host_write(csr_types_pkg::CSR_READ_FRAME_BASEL, $random(seed));
        host_write(csr_types_pkg::CSR_READ_FRAME_BASEH, $random(seed));
        host_write(csr_types_pkg::CSR_WRITE_FRAME_BASEL, $random(seed));
        host_write(csr_types_pkg::CSR_WRITE_FRAME_BASEH, $random(seed));
    endtask

    task automatic wait_requests_done();
        while (!req_valid) begin
            idle(1);
        end
        while (req_valid) begin
            idle(1);
        end
    endtask

    task automatic wait_dsm_write();
        while (!dsm_wr_valid) begin
            idle(1);
        end
        idle(1);
    endtask

    task automatic read_status(input csr_types_pkg::sreg_idx_t idx);
        host_write(csr_types_pkg::CSR_SREG_READ, 32'(idx));
        while (!sreg_rsp_valid) begin
            idle(1);
        end
        idle(1);
    endtask

    // Any assertion failure ends the run at once
    initial begin
        wait (i_dut.i_afu_assertions.fail_flag);
        report_failure();
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Watchdog timeout: the test sequence did not finish in time");
    end

    initial begin
        seed      = 32'h9074b4c7;
        test_name = "reset";
        arst_n    = 1'b0;
        cfg_valid = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        repeat (16) @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle(8);

        // No status area yet, so the test must finish without a DSM write
        test_name = "test without status area";
        set_frame_bases();
        host_write(csr_types_pkg::CSR_AFU_EN, 32'd1);
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd5);
        wait_requests_done();
        idle(4);

        test_name = "test with status area";
        host_write(csr_types_pkg::CSR_DSM_BASEL, 32'h0000_8000);
        host_write(csr_types_pkg::CSR_DSM_BASEH, 32'h0000_0001);
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd7);
        wait_dsm_write();

        test_name = "zero-line test";
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd0);
        wait_dsm_write();

        // A second start during the run is ignored and the disable cuts the run short
        test_name = "restart while busy and early stop";
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd20);
        while (!req_valid) begin
            idle(1);
        end
        idle(2);
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd3);
        idle(3);
        host_write(csr_types_pkg::CSR_AFU_EN, 32'd0);
        wait_dsm_write();

        test_name = "start while disabled";
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd6);
        idle(6);

        test_name = "status reads";
        read_status(csr_types_pkg::SREG_TESTS_DONE);
        read_status(csr_types_pkg::SREG_LINES_TOTAL);
        read_status(csr_types_pkg::SREG_ENGINE_BUSY);
        read_status(csr_types_pkg::SREG_DSM_BASEL);
        read_status(4'd9);

        // Busy is read back while the new test is still running
        test_name = "test on new frames";
        set_frame_bases();
        host_write(csr_types_pkg::CSR_AFU_EN, 32'd1);
        host_write(csr_types_pkg::CSR_ENABLE_TEST, 32'd8);
        read_status(csr_types_pkg::SREG_ENGINE_BUSY);
        wait_dsm_write();

        test_name = "final status reads";
        read_status(csr_types_pkg::SREG_TESTS_DONE);
        read_status(csr_types_pkg::SREG_LINES_TOTAL);
        idle(2);

        if (i_dut.i_afu_assertions.fail_flag) begin
            report_failure();
        end else begin
            $display("Result: PASSED");
            $finish;
        end
    end

endmodule

//--- compile.f
csr_types_pkg.sv
csr_decoder.sv
test_engine.sv
status_unit.sv
afu_top.sv
afu_assertions.sv
tb_afu_top.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and check the log for the pass line
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -j 0 --top-module tb_afu_top \
    -f compile.f -o tb_afu_top > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/tb_afu_top +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log
grep -qx "Result: PASSED" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
